// File: hdl/dmem_pkg.sv
// shared types and fixed widths for the data memory subsystem; BYTE_LANES is assumed to be a power of two
`default_nettype none

package dmem_pkg;

    parameter int ADDR_W     = 32;                     // byte address width
    parameter int DATA_W     = 32;                     // load/store data width
    parameter int BYTE_LANES = 4;                      // bytes per word
    parameter int OFF_W      = $clog2(BYTE_LANES);     // byte offset within a word
    parameter int WORD_ADDR_W = ADDR_W - OFF_W;        // word address on the RAM port

    // top bit marks a store, low three bits follow funct3
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,  // load byte, sign extended
        OP_LH  = 4'b0001,  // load half, sign extended
        OP_LW  = 4'b0010,  // load word
        OP_LBU = 4'b0100,  // load byte, zero extended
        OP_LHU = 4'b0101,  // load half, zero extended
        OP_SB  = 4'b1000,  // store byte
        OP_SH  = 4'b1001,  // store half
        OP_SW  = 4'b1010   // store word
    } mem_op_e;

    // config register selector
    typedef enum logic [1:0] {
        CFG_LIMIT  = 2'd0,  // highest legal byte address
        CFG_STRICT = 2'd1,  // bit 0 turns on strict alignment
        CFG_FAULTS = 2'd2   // saturating fault count, write clears
    } cfg_reg_e;

endpackage

`default_nettype wire

// File: hdl/dmem_port_if.sv
// word-wide RAM port; rdata is expected to follow addr with no clock in between
`timescale 1ns/1ps
`default_nettype none

interface dmem_port_if;
    import dmem_pkg::*;

    logic [WORD_ADDR_W-1:0] addr;   // word address
    logic                   we;     // write strobe
    logic [BYTE_LANES-1:0]  be;     // per-lane write enables
    logic [DATA_W-1:0]      wdata;  // lane-positioned store data
    logic [DATA_W-1:0]      rdata;  // combinational read word

    modport ctrl (
        output addr,
        output we,
        output be,
        output wdata,
        input  rdata
    );

    modport mem (
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: hdl/lsu_align.sv
// purely combinational lane logic; addresses are always rounded down, so misaligned must gate any write
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  wire dmem_pkg::mem_op_e                   op,
    input  wire logic [dmem_pkg::ADDR_W-1:0]         addr,
    input  wire logic                                strict,
    input  wire logic [dmem_pkg::DATA_W-1:0]         store_data,
    input  wire logic [dmem_pkg::DATA_W-1:0]         mem_rdata,
    output logic      [dmem_pkg::WORD_ADDR_W-1:0]    word_addr,
    output logic      [dmem_pkg::BYTE_LANES-1:0]     be,
    output logic      [dmem_pkg::DATA_W-1:0]         lane_wdata,
    output logic                                     misaligned,
    output logic                                     illegal,
    output logic      [dmem_pkg::DATA_W-1:0]         load_data
);
    import dmem_pkg::*;

    logic [BYTE_LANES-1:0] be_base;    // enables for offset zero
    logic [OFF_W-1:0]      keep_mask;  // offset bits kept after rounding
    logic [OFF_W-1:0]      lane_off;   // rounded byte offset
    logic [DATA_W-1:0]     shifted;    // read word with target lane at bit 0

    // access size decode and store lane replication
    always_comb begin
        be_base    = '0;
        keep_mask  = '1;
        lane_wdata = '0;
        illegal    = 1'b0;
        case (op)
            OP_LB, OP_LBU, OP_SB: begin
                be_base    = 4'b0001;
                keep_mask  = 2'b11;                          // bytes never round
                lane_wdata = {BYTE_LANES{store_data[7:0]}};  // byte in every lane
            end
            OP_LH, OP_LHU, OP_SH: begin
                be_base    = 4'b0011;
                keep_mask  = 2'b10;                          // drop bit 0
                lane_wdata = {2{store_data[15:0]}};          // half in both halves
            end
            OP_LW, OP_SW: begin
                be_base    = 4'b1111;
                keep_mask  = 2'b00;                          // word aligned
                lane_wdata = store_data;
            end
            default: begin
                illegal = 1'b1;                              // unknown funct3 or store form
            end
        endcase
    end

    assign lane_off   = addr[OFF_W-1:0] & keep_mask;
    assign word_addr  = addr[ADDR_W-1:OFF_W];
    assign be         = be_base << lane_off;
    // dropped offset bits only matter when strict is set
    assign misaligned = strict && ((addr[OFF_W-1:0] & ~keep_mask) != '0);

    assign shifted = mem_rdata >> {lane_off, 3'b000};  // lane to bit 0

    // load extension
    always_comb begin
        case (op)
            OP_LB:   load_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
            OP_LBU:  load_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            OP_LH:   load_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
            OP_LHU:  load_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            OP_LW:   load_data = shifted;
            default: load_data = '0;                   // stores and illegal ops
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
// byte-lane RAM with no reset; contents are undefined until written and MEM_BYTES must be a multiple of 4 and at least 8
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int MEM_BYTES = 1024  // RAM size in bytes
) (
    input wire logic  clk,
    dmem_port_if.mem  port
);
    import dmem_pkg::*;

    localparam int WORDS = MEM_BYTES / BYTE_LANES;  // word count
    localparam int IDX_W = $clog2(WORDS);           // index bits used from addr

    logic [BYTE_LANES-1:0][7:0] ram [WORDS];  // one byte per lane
    logic [IDX_W-1:0]           idx;          // word index

    // upper address bits are kept in range by the limit check upstream
    assign idx = port.addr[IDX_W-1:0];

    // byte-enabled write at the edge
    always_ff @(posedge clk) begin
        if (port.we) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (port.be[lane]) begin
                    ram[idx][lane] <= port.wdata[lane*8 +: 8];  // only enabled lanes
                end
            end
        end
    end

    assign port.rdata = ram[idx];  // async read, whole word

endmodule

`default_nettype wire

// File: hdl/lsu_ctrl.sv
// in-order request queue; the requester must hold a credit for every req_valid cycle and must always accept responses
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl #(
    parameter int CREDITS = 2  // queue depth and credits after reset
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req_valid,
    input  wire dmem_pkg::mem_op_e             req_op,
    input  wire logic [dmem_pkg::ADDR_W-1:0]   req_addr,
    input  wire logic [dmem_pkg::DATA_W-1:0]   req_wdata,
    output logic                               credit_return,
    output logic                               resp_valid,
    output logic      [dmem_pkg::DATA_W-1:0]   resp_rdata,
    output logic                               resp_fault,
    input  wire logic [dmem_pkg::ADDR_W-1:0]   limit,
    input  wire logic                          strict,
    output logic                               fault_pulse,
    dmem_port_if.ctrl                          mem
);
    import dmem_pkg::*;

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    mem_op_e           q_op    [CREDITS];  // queued payload
    logic [ADDR_W-1:0] q_addr  [CREDITS];
    logic [DATA_W-1:0] q_wdata [CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;              // entries held

    logic              pop;
    mem_op_e           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [ADDR_W:0]   last_byte;          // one extra bit so the end byte cannot wrap
    logic              misaligned;
    logic              illegal;
    logic              fault;
    logic [DATA_W-1:0] load_data;

    assign pop       = (count != '0);      // retire the head every cycle it exists
    assign head_op   = q_op[rd_ptr];
    assign head_addr = q_addr[rd_ptr];

    lsu_align u_align (
        .op         (head_op),
        .addr       (head_addr),
        .strict     (strict),
        .store_data (q_wdata[rd_ptr]),
        .mem_rdata  (mem.rdata),
        .word_addr  (mem.addr),
        .be         (mem.be),
        .lane_wdata (mem.wdata),
        .misaligned (misaligned),
        .illegal    (illegal),
        .load_data  (load_data)
    );

    // end byte from the unrounded address, op[1:0] is the log2 size
    assign last_byte   = {1'b0, head_addr} + (ADDR_W+1)'((1 << head_op[1:0]) - 1);
    assign fault       = illegal || misaligned || (last_byte > {1'b0, limit});
    assign fault_pulse = pop && fault;
    assign mem.we      = pop && head_op[3] && !fault;  // legal stores only

    // payload storage
    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_op[wr_ptr]    <= req_op;
            q_addr[wr_ptr]  <= req_addr;
            q_wdata[wr_ptr] <= req_wdata;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle or push and pop together
            endcase
        end
    end

    // response strobes, one cycle after the pop
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid    <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            resp_valid    <= pop;
            credit_return <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp_fault <= fault;
            resp_rdata <= (fault || head_op[3]) ? '0 : load_data;  // stores return zero
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_cfg.sv
// config registers; limit writes are clamped to the RAM and the fault count saturates at 255
`timescale 1ns/1ps
`default_nettype none

module lsu_cfg #(
    parameter int MEM_BYTES = 1024  // RAM size in bytes
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          cfg_we,
    input  wire dmem_pkg::cfg_reg_e            cfg_sel,
    input  wire logic [dmem_pkg::DATA_W-1:0]   cfg_wdata,
    output logic      [dmem_pkg::DATA_W-1:0]   cfg_rdata,
    input  wire logic                          fault_pulse,
    output logic      [dmem_pkg::ADDR_W-1:0]   limit,
    output logic                               strict
);
    import dmem_pkg::*;

    localparam int FCNT_W = 8;                                 // fault counter width
    localparam logic [ADDR_W-1:0] TOP = ADDR_W'(MEM_BYTES - 1);  // last RAM byte

    logic [FCNT_W-1:0] fault_cnt;

    // limit and strict, new value seen after the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            limit  <= TOP;                                     // whole RAM open
            strict <= 1'b0;                                    // relaxed rounding
        end else if (cfg_we) begin
            if (cfg_sel == CFG_LIMIT) begin
                limit <= (ADDR_W'(cfg_wdata) > TOP) ? TOP : ADDR_W'(cfg_wdata);
            end
            if (cfg_sel == CFG_STRICT) begin
                strict <= cfg_wdata[0];
            end
        end
    end

    // fault counter, a clear beats a same-cycle fault
    always_ff @(posedge clk) begin
        if (rst) begin
            fault_cnt <= '0;
        end else if (cfg_we && (cfg_sel == CFG_FAULTS)) begin
            fault_cnt <= '0;
        end else if (fault_pulse && (fault_cnt != '1)) begin
            fault_cnt <= fault_cnt + 1'b1;                     // hold at max
        end
    end

    // readback mux
    always_comb begin
        case (cfg_sel)
            CFG_LIMIT:  cfg_rdata = DATA_W'(limit);
            CFG_STRICT: cfg_rdata = {{(DATA_W-1){1'b0}}, strict};
            CFG_FAULTS: cfg_rdata = DATA_W'(fault_cnt);
            default:    cfg_rdata = '0;                        // unused selector
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/dmem_subsys.sv
// data memory top; requests need credits, responses are never stalled and RAM starts undefined
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys #(
    parameter int MEM_BYTES = 1024,  // RAM bytes, multiple of 4
    parameter int CREDITS   = 2      // queue depth and initial credits
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req_valid,
    input  wire dmem_pkg::mem_op_e             req_op,
    input  wire logic [dmem_pkg::ADDR_W-1:0]   req_addr,
    input  wire logic [dmem_pkg::DATA_W-1:0]   req_wdata,
    output logic                               credit_return,
    output logic                               resp_valid,
    output logic      [dmem_pkg::DATA_W-1:0]   resp_rdata,
    output logic                               resp_fault,
    input  wire logic                          cfg_we,
    input  wire dmem_pkg::cfg_reg_e            cfg_sel,
    input  wire logic [dmem_pkg::DATA_W-1:0]   cfg_wdata,
    output logic      [dmem_pkg::DATA_W-1:0]   cfg_rdata
);
    import dmem_pkg::*;

    logic [ADDR_W-1:0] limit;        // cfg to ctrl
    logic              strict;       // cfg to ctrl
    logic              fault_pulse;  // ctrl to cfg

    dmem_port_if mem_bus ();

    lsu_cfg #(
        .MEM_BYTES (MEM_BYTES)
    ) u_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_sel     (cfg_sel),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .fault_pulse (fault_pulse),
        .limit       (limit),
        .strict      (strict)
    );

    lsu_ctrl #(
        .CREDITS (CREDITS)
    ) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .credit_return (credit_return),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_fault    (resp_fault),
        .limit         (limit),
        .strict        (strict),
        .fault_pulse   (fault_pulse),
        .mem           (mem_bus.ctrl)
    );

    data_mem #(
        .MEM_BYTES (MEM_BYTES)
    ) u_mem (
        .clk  (clk),
        .port (mem_bus.mem)
    );

endmodule

`default_nettype wire

// File: dv/dmem_subsys_assertions.sv
// credit and response protocol checks bound into dmem_subsys; assumes a synchronous active-high reset
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys_assertions #(
    parameter int CREDITS = 2  // credits the requester starts with
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic req_valid,
    input wire logic credit_return,
    input wire logic resp_valid
);
    logic [7:0]  outstanding;     // requests whose credit is still out
    int unsigned fail_count = 0;  // assertion failures so far

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + {7'd0, req_valid} - {7'd0, credit_return};
        end
    end

    credit_low_after_reset: assert property (@(posedge clk) rst |=> !credit_return)
        else begin
            fail_count++;
            $error("credit_return high in the cycle after reset");
        end

    credit_bound: assert property (@(posedge clk) disable iff (rst) outstanding <= CREDITS)
        else begin
            fail_count++;
            $error("more requests outstanding than credits");
        end

    credit_with_resp: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> resp_valid)
        else begin
            fail_count++;
            $error("credit_return without resp_valid");
        end

endmodule

bind dmem_subsys dmem_subsys_assertions #(
    .CREDITS (CREDITS)
) u_assertions (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .resp_valid    (resp_valid)
);

`default_nettype wire

// File: dv/dmem_subsys_tb.sv
// vector-driven testbench; run from the project root so dv/dmem_vectors.hex is found
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys_tb;
    import dmem_pkg::*;

    localparam int MEM_BYTES = 1024;
    localparam int CREDITS   = 2;
    localparam int MAX_RECS  = 64;   // record slots in the vector image
    localparam int TIMEOUT   = 200;  // cycles allowed for any wait

    logic              clk;
    logic              rst;
    logic              req_valid;
    mem_op_e           req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              credit_return;
    logic              resp_valid;
    logic [DATA_W-1:0] resp_rdata;
    logic              resp_fault;
    logic              cfg_we;
    cfg_reg_e          cfg_sel;
    logic [DATA_W-1:0] cfg_wdata;
    logic [DATA_W-1:0] cfg_rdata;

    logic [31:0]       vec_mem [0:6*MAX_RECS-1];  // six words per record
    logic [DATA_W:0]   exp_q [$];                 // {fault, data} per pending request
    logic [DATA_W:0]   exp_head;
    int                credits;                   // requester side credit model

    dmem_subsys #(.MEM_BYTES(MEM_BYTES), .CREDITS(CREDITS)) dut0 (.*);

    always #10 clk = ~clk;  // 20 ns period

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_resp(input logic [DATA_W-1:0] exp_data, input logic exp_fault);
        if (resp_fault !== exp_fault) begin
            $display("Mismatch resp_fault: got %h expected %h", resp_fault, exp_fault);
            abort_run();
        end else if (resp_rdata !== exp_data) begin
            $display("Mismatch resp_rdata: got %h expected %h", resp_rdata, exp_data);
            abort_run();
        end
    endtask

    task automatic check_cfg(input cfg_reg_e sel, input logic [DATA_W-1:0] exp_data);
        if (cfg_rdata !== exp_data) begin
            $display("Mismatch cfg_rdata sel %h: got %h expected %h", sel, cfg_rdata, exp_data);
            abort_run();
        end
    endtask

    task automatic check_credits(input int exp_credits);
        if (credits != exp_credits) begin
            $display("Mismatch credits: got %h expected %h", credits, exp_credits);
            abort_run();
        end
    endtask

    // sampled at the edge, so outputs hold their pre-edge values
    always @(posedge clk) begin
        if (dut0.u_assertions.fail_count != 0) begin
            $display("A protocol assertion failed");
            abort_run();
        end else if (!rst) begin
            if (credit_return) begin
                credits++;  // credit usable from the next drive edge
            end
            if (resp_valid && exp_q.size() == 0) begin
                $display("Response arrived with no request outstanding");
                abort_run();
            end else if (resp_valid) begin
                exp_head = exp_q.pop_front();
                check_resp(exp_head[DATA_W-1:0], exp_head[DATA_W]);
            end
        end
    end

    task automatic drain_responses();
        int waited;
        waited = 0;
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timed out waiting for outstanding responses");
                abort_run();
            end
        end
    endtask

    task automatic issue_req(input logic [31:0] op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_data,
                             input logic exp_fault, input logic gap);
        int waited;
        int idle;
        waited = 0;
        req_valid = 1'b0;
        if (gap) begin
            idle = $urandom % 3;  // 0..2 idle cycles
            repeat (idle) @(negedge clk);
        end
        while (credits == 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timed out waiting for a request credit");
                abort_run();
            end
        end
        req_valid = 1'b1;
        req_op    = mem_op_e'(op[3:0]);
        req_addr  = addr;
        req_wdata = wdata;
        credits--;
        exp_q.push_back({exp_fault, exp_data});
        @(negedge clk);
    endtask

    task automatic cfg_write(input logic [31:0] sel, input logic [31:0] data);
        drain_responses();  // config changes only between requests
        cfg_we    = 1'b1;
        cfg_sel   = cfg_reg_e'(sel[1:0]);
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic cfg_read(input logic [31:0] sel, input logic [31:0] exp_data);
        drain_responses();
        cfg_sel = cfg_reg_e'(sel[1:0]);
        @(negedge clk);
        check_cfg(cfg_sel, exp_data);
    endtask

    initial begin : run_vectors
        int          rec;
        logic        done;
        logic [31:0] kind;
        logic [31:0] op_w;
        logic [31:0] addr_w;
        logic [31:0] wdata_w;
        logic [31:0] exp_w;
        logic [31:0] fault_w;
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = OP_LB;
        req_addr    = '0;
        req_wdata   = '0;
        cfg_we      = 1'b0;
        cfg_sel     = CFG_LIMIT;
        cfg_wdata   = '0;
        credits     = CREDITS;
        done        = 1'b0;
        void'($urandom(32'h1423));
        $readmemh("dv/dmem_vectors.hex", vec_mem);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (rec = 0; rec < MAX_RECS && !done; rec++) begin
            kind    = vec_mem[6*rec];
            op_w    = vec_mem[6*rec+1];
            addr_w  = vec_mem[6*rec+2];
            wdata_w = vec_mem[6*rec+3];
            exp_w   = vec_mem[6*rec+4];
            fault_w = vec_mem[6*rec+5];
            case (kind)
                32'h0: done = 1'b1;
                32'h1: issue_req(op_w, addr_w, wdata_w, exp_w, fault_w[0], 1'b1);
                32'h4: issue_req(op_w, addr_w, wdata_w, exp_w, fault_w[0], 1'b0);
                32'h2: cfg_write(op_w, wdata_w);
                32'h3: cfg_read(op_w, exp_w);
                default: begin
                    $display("Unknown record kind in vector file at record %0d", rec);
                    abort_run();
                end
            endcase
        end
        drain_responses();
        check_credits(CREDITS);  // every credit back home
        if (dut0.u_assertions.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("A protocol assertion failed near the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: dmem_subsys.f
hdl/dmem_pkg.sv
hdl/dmem_port_if.sv
hdl/lsu_align.sv
hdl/data_mem.sv
hdl/lsu_ctrl.sv
hdl/lsu_cfg.sv
hdl/dmem_subsys.sv
dv/dmem_subsys_assertions.sv
dv/dmem_subsys_tb.sv

// File: dv/dmem_vectors.hex
// kind op/sel addr wdata exp_data exp_fault, all hex
// kind 1 request after random gap, 4 back-to-back request, 2 cfg write, 3 cfg read check, 0 end
1 a 00000010 11223344 00000000 0
1 8 00000011 000000a5 00000000 0
1 0 00000011 00000000 ffffffa5 0
1 4 00000011 00000000 000000a5 0
1 9 00000012 0000beef 00000000 0
1 1 00000012 00000000 ffffbeef 0
1 5 00000012 00000000 0000beef 0
1 2 00000010 00000000 beefa544 0
1 5 00000010 00000000 0000a544 0
1 1 00000013 00000000 ffffbeef 0
1 2 00000011 00000000 beefa544 0
2 1 00000000 00000001 00000000 0
1 9 00000011 00001234 00000000 1
1 1 00000011 00000000 00000000 1
1 2 00000010 00000000 beefa544 0
2 1 00000000 00000000 00000000 0
2 0 00000000 00000012 00000000 0
1 2 00000010 00000000 00000000 1
1 8 00000013 00000077 00000000 1
1 3 00000010 00000000 00000000 1
3 2 00000000 00000000 00000005 0
2 2 00000000 00000000 00000000 0
3 2 00000000 00000000 00000000 0
2 0 00000000 ffffffff 00000000 0
3 0 00000000 00000000 000003ff 0
1 2 00000010 00000000 beefa544 0
4 a 00000040 01020304 00000000 0
4 a 00000044 a0b0c0d0 00000000 0
4 2 00000040 00000000 01020304 0
4 2 00000044 00000000 a0b0c0d0 0
0 0 00000000 00000000 00000000 0
